//--- hdl/mem_access_stage.sv
module mem_access_stage (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   head_valid_i,
    input  mem_op_pkg::mem_kind_e                  kind_i,
    input  logic [mem_data_pkg::MEM_ADDR_BITS-1:0] index_i,
    input  mem_op_pkg::byte_mask_t                 mask_i,
    input  mem_data_pkg::mem_lane_u                wdata_i,
    input  mem_op_pkg::funct3_t                    funct3_i,
    input  logic [1:0]                             offset_i,
    output logic                                   pop_o,
    output logic                                   rsp_valid_o,
    input  logic                                   rsp_ready_i,
    output mem_data_pkg::word_t                    rsp_data_o,
    output logic                                   rsp_trap_o
);
    import mem_op_pkg::*;
    import mem_data_pkg::*;

    word_t      mem [MEM_WORDS];
    mem_lane_u  rd_lane;
    logic [7:0] sel_byte;
    logic [15:0] sel_half;
    word_t      load_data;

    // take the head when the response slot is free or draining
    assign pop_o = head_valid_i && (!rsp_valid_o || rsp_ready_i);

    always_comb begin
        rd_lane.word = mem[index_i];
        sel_byte     = rd_lane.bytes[offset_i];
        sel_half     = rd_lane.halves[offset_i[1]];  // halfword aligned
        case (funct3_i)
            F3_LB:   load_data = {{(WORD_BITS-8){sel_byte[7]}}, sel_byte};
            F3_LBU:  load_data = {{(WORD_BITS-8){1'b0}}, sel_byte};
            F3_LH:   load_data = {{(WORD_BITS-16){sel_half[15]}}, sel_half};
            F3_LHU:  load_data = {{(WORD_BITS-16){1'b0}}, sel_half};
            default: load_data = rd_lane.word;  // lw
        endcase
    end

    // stores write only the enabled lanes
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            for (int w = 0; w < MEM_WORDS; w++) begin
                mem[w] <= '0;
            end
        end else if (pop_o && (kind_i == kind_store)) begin
            for (int l = 0; l < BYTE_LANES; l++) begin
                if (mask_i[l])
                    mem[index_i][l*8 +: 8] <= wdata_i.bytes[l];
            end
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            rsp_valid_o <= 1'b0;
        end else if (pop_o) begin
            rsp_valid_o <= 1'b1;  // refill in the same edge it drains
        end else if (rsp_ready_i) begin
            rsp_valid_o <= 1'b0;
        end
    end

    // held while rsp_ready_i is low since pop_o is low then
    always_ff @(posedge clk) begin
        if (pop_o) begin
            rsp_trap_o <= (kind_i == kind_trap);
            if (kind_i == kind_load)
                rsp_data_o <= load_data;
            else
                rsp_data_o <= '0;  // stores and traps return zero
        end
    end

endmodule : mem_access_stage

//--- hdl/mem_access_top.sv
module mem_access_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 req_valid_i,
    output logic                 req_ready_o,
    input  mem_op_pkg::funct3_t  req_funct3_i,
    input  logic                 req_is_store_i,
    input  mem_data_pkg::word_t  req_addr_i,
    input  mem_data_pkg::word_t  req_wdata_i,
    output logic                 rsp_valid_o,
    input  logic                 rsp_ready_i,
    output mem_data_pkg::word_t  rsp_data_o,
    output logic                 rsp_trap_o
);
    import mem_op_pkg::*;
    import mem_data_pkg::*;

    // generator to queue
    logic                     push;
    mem_kind_e                gen_kind;
    logic [MEM_ADDR_BITS-1:0] gen_index;
    byte_mask_t               gen_mask;
    mem_lane_u                gen_wdata;
    funct3_t                  gen_funct3;
    logic [1:0]               gen_offset;
    logic                     credit;

    // queue head to stage
    logic                     head_valid;
    mem_kind_e                head_kind;
    logic [MEM_ADDR_BITS-1:0] head_index;
    byte_mask_t               head_mask;
    mem_lane_u                head_wdata;
    funct3_t                  head_funct3;
    logic [1:0]               head_offset;
    logic                     pop;

    mem_request_gen u_gen (
        .clk            (clk),
        .rst            (rst),
        .req_valid_i    (req_valid_i),
        .req_ready_o    (req_ready_o),
        .req_funct3_i   (req_funct3_i),
        .req_is_store_i (req_is_store_i),
        .req_addr_i     (req_addr_i),
        .req_wdata_i    (req_wdata_i),
        .credit_i       (credit),
        .push_o         (push),
        .kind_o         (gen_kind),
        .index_o        (gen_index),
        .mask_o         (gen_mask),
        .wdata_o        (gen_wdata),
        .funct3_o       (gen_funct3),
        .offset_o       (gen_offset)
    );

    mem_request_queue u_queue (
        .clk          (clk),
        .rst          (rst),
        .push_i       (push),
        .kind_i       (gen_kind),
        .index_i      (gen_index),
        .mask_i       (gen_mask),
        .wdata_i      (gen_wdata),
        .funct3_i     (gen_funct3),
        .offset_i     (gen_offset),
        .head_valid_o (head_valid),
        .kind_o       (head_kind),
        .index_o      (head_index),
        .mask_o       (head_mask),
        .wdata_o      (head_wdata),
        .funct3_o     (head_funct3),
        .offset_o     (head_offset),
        .pop_i        (pop),
        .credit_o     (credit)
    );

    mem_access_stage u_stage (
        .clk          (clk),
        .rst          (rst),
        .head_valid_i (head_valid),
        .kind_i       (head_kind),
        .index_i      (head_index),
        .mask_i       (head_mask),
        .wdata_i      (head_wdata),
        .funct3_i     (head_funct3),
        .offset_i     (head_offset),
        .pop_o        (pop),
        .rsp_valid_o  (rsp_valid_o),
        .rsp_ready_i  (rsp_ready_i),
        .rsp_data_o   (rsp_data_o),
        .rsp_trap_o   (rsp_trap_o)
    );

endmodule : mem_access_top

//--- hdl/mem_data_pkg.sv
package mem_data_pkg;

    localparam int WORD_BITS     = 32;
    localparam int BYTE_LANES    = 4;
    localparam int MEM_WORDS     = 64;
    localparam int MEM_ADDR_BITS = 6;  // address bits 7:2
    localparam int QUEUE_DEPTH   = 4;
    localparam int CREDIT_BITS   = 3;  // holds 0..QUEUE_DEPTH

    typedef logic [WORD_BITS-1:0] word_t;

    // one data word seen as a whole, as bytes or as halfwords
    typedef union packed {
        word_t                         word;
        logic [BYTE_LANES-1:0][7:0]    bytes;
        logic [1:0][15:0]              halves;
    } mem_lane_u;

endpackage : mem_data_pkg

//--- hdl/mem_op_pkg.sv
package mem_op_pkg;

    // what a queued request does at the memory stage
    typedef enum logic [1:0] {
        kind_load  = 2'b00,
        kind_store = 2'b01,
        kind_trap  = 2'b10
    } mem_kind_e;

    typedef logic [2:0] funct3_t;

    // rv32i load funct3 codes
    localparam funct3_t F3_LB  = 3'b000;
    localparam funct3_t F3_LH  = 3'b001;
    localparam funct3_t F3_LW  = 3'b010;
    localparam funct3_t F3_LBU = 3'b100;
    localparam funct3_t F3_LHU = 3'b101;

    // rv32i store funct3 codes
    localparam funct3_t F3_SB  = 3'b000;
    localparam funct3_t F3_SH  = 3'b001;
    localparam funct3_t F3_SW  = 3'b010;

    typedef logic [3:0] byte_mask_t;

    // unshifted enables, lane 0 based
    localparam byte_mask_t MASK_BYTE = 4'b0001;
    localparam byte_mask_t MASK_HALF = 4'b0011;
    localparam byte_mask_t MASK_WORD = 4'b1111;

endpackage : mem_op_pkg

//--- hdl/mem_request_gen.sv
module mem_request_gen (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   req_valid_i,
    output logic                                   req_ready_o,
    input  mem_op_pkg::funct3_t                    req_funct3_i,
    input  logic                                   req_is_store_i,
    input  mem_data_pkg::word_t                    req_addr_i,
    input  mem_data_pkg::word_t                    req_wdata_i,
    input  logic                                   credit_i,
    output logic                                   push_o,
    output mem_op_pkg::mem_kind_e                  kind_o,
    output logic [mem_data_pkg::MEM_ADDR_BITS-1:0] index_o,
    output mem_op_pkg::byte_mask_t                 mask_o,
    output mem_data_pkg::mem_lane_u                wdata_o,
    output mem_op_pkg::funct3_t                    funct3_o,
    output logic [1:0]                             offset_o
);
    import mem_op_pkg::*;
    import mem_data_pkg::*;

    logic [CREDIT_BITS-1:0] credit_cnt;
    logic                   accept;
    mem_kind_e              kind_d;
    byte_mask_t             size_mask;
    byte_mask_t             mask_d;
    mem_lane_u              lane_d;

    assign req_ready_o = (credit_cnt != '0);  // spent at accept, not at push
    assign accept      = req_valid_i && req_ready_o;

    always_comb begin
        kind_d    = kind_trap;
        size_mask = '0;
        if (req_is_store_i) begin
            kind_d = kind_store;
            case (req_funct3_i)
                F3_SB:   size_mask = MASK_BYTE;
                F3_SH:   size_mask = MASK_HALF;
                F3_SW:   size_mask = MASK_WORD;
                default: kind_d = kind_trap;
            endcase
        end else begin
            kind_d = kind_load;
            case (req_funct3_i)
                F3_LB, F3_LBU: size_mask = MASK_BYTE;
                F3_LH, F3_LHU: size_mask = MASK_HALF;
                F3_LW:         size_mask = MASK_WORD;
                default:       kind_d = kind_trap;
            endcase
        end
    end

    // halves sit on a halfword boundary, bytes anywhere
    always_comb begin
        lane_d.word = '0;
        mask_d      = '0;
        case (size_mask)
            MASK_BYTE: begin
                lane_d.bytes[req_addr_i[1:0]] = req_wdata_i[7:0];
                mask_d = MASK_BYTE << req_addr_i[1:0];
            end
            MASK_HALF: begin
                lane_d.halves[req_addr_i[1]] = req_wdata_i[15:0];
                mask_d = MASK_HALF << {req_addr_i[1], 1'b0};
            end
            MASK_WORD: begin
                lane_d.word = req_wdata_i;
                mask_d      = MASK_WORD;
            end
            default: mask_d = '0;  // trap touches no lane
        endcase
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            credit_cnt <= CREDIT_BITS'(QUEUE_DEPTH);
            push_o     <= 1'b0;
        end else begin
            push_o     <= accept;
            credit_cnt <= credit_cnt - CREDIT_BITS'(accept) + CREDIT_BITS'(credit_i);
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            kind_o   <= kind_d;
            index_o  <= req_addr_i[MEM_ADDR_BITS+1:2];  // word aligned
            mask_o   <= mask_d;
            wdata_o  <= lane_d;
            funct3_o <= req_funct3_i;
            offset_o <= req_addr_i[1:0];
        end
    end

endmodule : mem_request_gen

//--- hdl/mem_request_queue.sv
module mem_request_queue (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   push_i,
    input  mem_op_pkg::mem_kind_e                  kind_i,
    input  logic [mem_data_pkg::MEM_ADDR_BITS-1:0] index_i,
    input  mem_op_pkg::byte_mask_t                 mask_i,
    input  mem_data_pkg::mem_lane_u                wdata_i,
    input  mem_op_pkg::funct3_t                    funct3_i,
    input  logic [1:0]                             offset_i,
    output logic                                   head_valid_o,
    output mem_op_pkg::mem_kind_e                  kind_o,
    output logic [mem_data_pkg::MEM_ADDR_BITS-1:0] index_o,
    output mem_op_pkg::byte_mask_t                 mask_o,
    output mem_data_pkg::mem_lane_u                wdata_o,
    output mem_op_pkg::funct3_t                    funct3_o,
    output logic [1:0]                             offset_o,
    input  logic                                   pop_i,
    output logic                                   credit_o
);
    import mem_op_pkg::*;
    import mem_data_pkg::*;

    mem_kind_e                  kind_q   [QUEUE_DEPTH];
    logic [MEM_ADDR_BITS-1:0]   index_q  [QUEUE_DEPTH];
    byte_mask_t                 mask_q   [QUEUE_DEPTH];
    mem_lane_u                  wdata_q  [QUEUE_DEPTH];
    funct3_t                    funct3_q [QUEUE_DEPTH];
    logic [1:0]                 offset_q [QUEUE_DEPTH];

    logic [$clog2(QUEUE_DEPTH)-1:0] wr_ptr;
    logic [$clog2(QUEUE_DEPTH)-1:0] rd_ptr;
    logic [CREDIT_BITS-1:0]         count;
    logic                           do_pop;

    assign head_valid_o = (count != '0);
    assign do_pop       = pop_i && head_valid_o;
    assign credit_o     = do_pop;  // one slot freed per pop

    assign kind_o   = kind_q[rd_ptr];
    assign index_o  = index_q[rd_ptr];
    assign mask_o   = mask_q[rd_ptr];
    assign wdata_o  = wdata_q[rd_ptr];
    assign funct3_o = funct3_q[rd_ptr];
    assign offset_o = offset_q[rd_ptr];

    // no full check, the producer never pushes without a credit
    always_ff @(posedge clk) begin
        if (push_i) begin
            kind_q[wr_ptr]   <= kind_i;
            index_q[wr_ptr]  <= index_i;
            mask_q[wr_ptr]   <= mask_i;
            wdata_q[wr_ptr]  <= wdata_i;
            funct3_q[wr_ptr] <= funct3_i;
            offset_q[wr_ptr] <= offset_i;
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_i)
                wr_ptr <= wr_ptr + 1'b1;  // depth is a power of two
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            count <= count + CREDIT_BITS'(push_i) - CREDIT_BITS'(do_pop);
        end
    end

endmodule : mem_request_queue

//--- mem_access_top.f
hdl/mem_op_pkg.sv
hdl/mem_data_pkg.sv
hdl/mem_request_gen.sv
hdl/mem_request_queue.sv
hdl/mem_access_stage.sv
hdl/mem_access_top.sv
tb/tb_mem_access_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator, pass only on the pass message
cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 --timescale 1ns/1ps \
    --top-module tb_mem_access_top -f mem_access_top.f \
    && ./obj_dir/Vtb_mem_access_top | tee /dev/stderr | grep -qF '*** PASSED ***' \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- tb/tb_mem_access_top.sv
module tb_mem_access_top;
    timeunit 1ns;
    timeprecision 1ps;

    import mem_op_pkg::*;
    import mem_data_pkg::*;

    localparam int SEED           = 43;
    localparam int RESET_CYCLES   = 10;
    localparam int N_WORD         = 16;
    localparam int N_SUB          = 24;
    localparam int N_EXT          = 24;
    localparam int N_TRAP         = 12;
    localparam int N_BP           = 40;
    localparam int TOTAL_REQ      = 2*N_WORD + 2*N_SUB + 2*N_EXT + 2*N_TRAP + N_BP;
    localparam int TIMEOUT_CYCLES = 20*TOTAL_REQ + RESET_CYCLES;

    logic                clk = 1'b0;
    logic                rst;
    logic                req_valid_i;
    logic                req_ready_o;
    mem_op_pkg::funct3_t req_funct3_i;
    logic                req_is_store_i;
    mem_data_pkg::word_t req_addr_i;
    mem_data_pkg::word_t req_wdata_i;
    logic                rsp_valid_o;
    logic                rsp_ready_i;
    mem_data_pkg::word_t rsp_data_o;
    logic                rsp_trap_o;

    mem_data_pkg::word_t model_mem [mem_data_pkg::MEM_WORDS];
    mem_data_pkg::word_t exp_data_q [$];
    logic                exp_trap_q [$];

    int   errors = 0;
    int   err_mark = 0;
    int   n_checks = 0;
    int   cycle_cnt = 0;
    int   phase_left = 0;
    logic bp_mode = 1'b0;
    logic saw_ready_low = 1'b0;

    mem_access_top DUT (.*);

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("run timed out after %0d cycles, responses still missing", cycle_cnt);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // response side, random stall stretches in back-pressure mode
    always @(posedge clk) begin
        #2;
        if (!bp_mode) begin
            rsp_ready_i = 1'b1;
        end else if (phase_left == 0) begin
            rsp_ready_i = !rsp_ready_i;
            phase_left  = rsp_ready_i ? int'($urandom_range(4, 1)) : int'($urandom_range(15, 4));
        end else begin
            phase_left--;
        end
    end

    task automatic check_data(input mem_data_pkg::word_t got, input mem_data_pkg::word_t exp);
        n_checks++;
        if (got !== exp) begin
            $display("MISMATCH rsp_data_o: got %h expected %h", got, exp);
            errors++;
        end
    endtask

    task automatic check_trap(input logic got, input logic exp);
        n_checks++;
        if (got !== exp) begin
            $display("MISMATCH rsp_trap_o: got %h expected %h", got, exp);
            errors++;
        end
    endtask

    // transfers are sampled mid cycle, ahead of the edge that takes them
    always @(negedge clk) begin
        if (!rst && rsp_valid_o && rsp_ready_i) begin
            if (exp_data_q.size() == 0) begin
                $display("response seen with no request outstanding");
                errors++;
            end else begin
                check_data(rsp_data_o, exp_data_q.pop_front());
                check_trap(rsp_trap_o, exp_trap_q.pop_front());
            end
        end
        if (bp_mode && !rsp_ready_i && !req_ready_o)
            saw_ready_low = 1'b1;
    end

    // reference model, applied in acceptance order
    task automatic model_accept(input funct3_t f3, input logic st, input word_t addr,
                                input word_t wd);
        word_t       cur;
        word_t       rsp;
        logic        trap;
        logic [5:0]  idx;
        logic [4:0]  sh;
        logic [7:0]  b;
        logic [15:0] h;
        idx  = addr[7:2];
        sh   = {addr[1:0], 3'b000};  // offset times 8
        cur  = model_mem[idx];
        rsp  = '0;
        trap = 1'b0;
        b    = 8'(cur >> sh);
        h    = 16'(cur >> sh);
        if (st) begin
            case (f3)
                F3_SB:   model_mem[idx] = (cur & ~(32'h0000_00ff << sh)) | ({24'h0, wd[7:0]} << sh);
                F3_SH:   model_mem[idx] = (cur & ~(32'h0000_ffff << sh)) | ({16'h0, wd[15:0]} << sh);
                F3_SW:   model_mem[idx] = wd;
                default: trap = 1'b1;
            endcase
        end else begin
            case (f3)
                F3_LB:   rsp = {{24{b[7]}}, b};
                F3_LBU:  rsp = {24'h0, b};
                F3_LH:   rsp = {{16{h[15]}}, h};
                F3_LHU:  rsp = {16'h0, h};
                F3_LW:   rsp = cur;
                default: trap = 1'b1;
            endcase
        end
        exp_data_q.push_back(rsp);
        exp_trap_q.push_back(trap);
    endtask

    function automatic logic [1:0] align_off(input funct3_t f3, input logic [1:0] off);
        case (f3[1:0])
            2'b01:   return {off[1], 1'b0};  // halfword
            2'b10:   return 2'b00;           // word
            default: return off;
        endcase
    endfunction

    function automatic logic valid_code(input funct3_t f3, input logic st);
        if (st)
            return (f3 == F3_SB) || (f3 == F3_SH) || (f3 == F3_SW);
        return (f3 != 3'd3) && (f3 != 3'd6) && (f3 != 3'd7);
    endfunction

    // called at posedge+2, returns at posedge+2 after the accepting edge
    task automatic send_req(input funct3_t f3, input logic st, input logic [5:0] idx,
                            input logic [1:0] off, input word_t wd);
        word_t r;
        logic  acc;
        r = $urandom;  // bits above 7 are not decoded
        req_valid_i    = 1'b1;
        req_funct3_i   = f3;
        req_is_store_i = st;
        req_addr_i     = {r[31:8], idx, off};
        req_wdata_i    = wd;
        do begin
            @(negedge clk);
            acc = req_ready_o;
            if (acc)
                model_accept(f3, st, req_addr_i, wd);
            @(posedge clk);
            #2;
        end while (!acc);
        req_valid_i = 1'b0;
    endtask

    task automatic report_test(input string name);
        while (exp_data_q.size() != 0) begin
            @(posedge clk);
            #2;
        end
        $display("test %-20s %s (%0d errors)", name,
                 (errors == err_mark) ? "ok" : "failed", errors - err_mark);
        err_mark = errors;
    endtask

    initial begin
        funct3_t    f3;
        logic       st;
        logic [5:0] idx;
        logic [1:0] off;
        logic [5:0] addrs [N_WORD];
        void'($urandom(SEED));
        rst            = 1'b1;
        req_valid_i    = 1'b0;
        req_funct3_i   = '0;
        req_is_store_i = 1'b0;
        req_addr_i     = '0;
        req_wdata_i    = '0;
        rsp_ready_i    = 1'b1;
        for (int i = 0; i < MEM_WORDS; i++)
            model_mem[i] = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst = 1'b0;

        for (int i = 0; i < N_WORD; i++) begin
            addrs[i] = 6'($urandom);
            send_req(F3_SW, 1'b1, addrs[i], 2'b00, $urandom);
        end
        for (int i = 0; i < N_WORD; i++)
            send_req(F3_LW, 1'b0, addrs[i], 2'b00, $urandom);
        report_test("word round trip");

        for (int i = 0; i < N_SUB; i++) begin
            f3  = ($urandom_range(1, 0) == 0) ? F3_SB : F3_SH;
            idx = 6'($urandom);
            off = align_off(f3, 2'($urandom));
            send_req(f3, 1'b1, idx, off, $urandom);
            send_req(F3_LW, 1'b0, idx, 2'b00, $urandom);
        end
        report_test("sub-word stores");

        for (int i = 0; i < N_EXT; i++) begin
            idx = 6'($urandom);
            send_req(F3_SW, 1'b1, idx, 2'b00, $urandom);
            case ($urandom_range(3, 0))
                0:       f3 = F3_LB;
                1:       f3 = F3_LH;
                2:       f3 = F3_LBU;
                default: f3 = F3_LHU;
            endcase
            send_req(f3, 1'b0, idx, align_off(f3, 2'($urandom)), $urandom);
        end
        report_test("extension");

        for (int i = 0; i < N_TRAP; i++) begin
            do begin
                f3 = 3'($urandom);
                st = 1'($urandom);
            end while (valid_code(f3, st));
            idx = 6'($urandom);
            send_req(f3, st, idx, 2'($urandom), $urandom);
            send_req(F3_LW, 1'b0, idx, 2'b00, $urandom);  // memory must be untouched
        end
        report_test("trap");

        bp_mode = 1'b1;
        for (int i = 0; i < N_BP; i++) begin
            f3 = 3'($urandom);
            st = 1'($urandom);
            send_req(f3, st, 6'($urandom), align_off(f3, 2'($urandom)), $urandom);
        end
        bp_mode = 1'b0;
        if (!saw_ready_low) begin
            $display("req_ready_o never fell while responses were stalled");
            errors++;
        end
        report_test("back-pressure order");

        $display("checks %0d, errors %0d", n_checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule : tb_mem_access_top
